/* common/cache_axi_pkg.sv */
`default_nettype none

package cache_axi_pkg;

    // bus and line geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_W     = 512;
    localparam int LINE_BEATS = LINE_W / DATA_W;    // 16 beats per line

    // fixed burst shape for every line transfer
    localparam logic [7:0] BURST_LEN  = 8'd15;      // len + 1 = 16 beats
    localparam logic [2:0] BURST_SIZE = 3'd2;       // 4 bytes per beat
    localparam logic [1:0] BURST_INCR = 2'd1;

    // read ids tell the requesters apart on the shared channel
    localparam logic [3:0] ID_INSTR = 4'd0;
    localparam logic [3:0] ID_DATA  = 4'd1;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_IADDR,
        RD_IDATA,
        RD_DADDR,
        RD_DDATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef struct packed {
        logic [3:0]        id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;                                     // 49 bits

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;                                     // 45 bits

    typedef struct packed {
        logic [3:0]        id;
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_r_t;                                      // 37 bits

    // data cache write request, strobe is per byte of one beat
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [LINE_W-1:0]   data;
        logic [DATA_W/8-1:0] strobe;
    } line_wr_req_t;                                // 548 bits

endpackage

`default_nettype wire

/* axi_bridge/line_assembler.sv */
`default_nettype none

module line_assembler
    import cache_axi_pkg::*;
(
    input  wire logic                     i_aclk,
    input  wire logic                     i_aresetn,
    input  wire logic                     i_shift,   // accepted beat, not last
    input  wire logic [DATA_W-1:0]        i_beat,
    output logic [LINE_W-DATA_W-1:0]      o_bits
);

    // 15 words, the last beat of a line never lands here
    logic [LINE_W-DATA_W-1:0] bits_q;

    // new beat enters at the top and older words move down one slot,
    // so the first beat of the burst ends up in the lowest word
    always_ff @(posedge i_aclk or negedge i_aresetn)
    begin
        if (!i_aresetn)
        begin
            bits_q <= '0;
        end
        else if (i_shift)
        begin
            bits_q <= {i_beat, bits_q[LINE_W-DATA_W-1:DATA_W]};
        end
    end

    assign o_bits = bits_q;

endmodule

`default_nettype wire

/* axi_bridge/line_read_engine.sv */
`default_nettype none

module line_read_engine
    import cache_axi_pkg::*;
(
    input  wire logic              i_aclk,
    input  wire logic              i_aresetn,

    input  wire logic              i_i_rvalid,
    input  wire logic [ADDR_W-1:0] i_i_raddr,
    input  wire logic              i_d_rvalid,
    input  wire logic [ADDR_W-1:0] i_d_raddr,

    output logic                   o_i_rready,
    output logic [LINE_W-1:0]      o_i_rdata,
    output logic                   o_d_rready,
    output logic [LINE_W-1:0]      o_d_rdata,

    output axi_ar_t                o_ar,
    output logic                   o_ar_valid,
    input  wire logic              i_ar_ready,

    input  wire axi_r_t            i_r,
    input  wire logic              i_r_valid,
    output logic                   o_r_ready
);

    rd_state_e                  state_q;
    rd_state_e                  state_d;
    logic [ADDR_W-1:0]          addr_q;    // address of the line in flight
    logic [LINE_W-DATA_W-1:0]   asm_bits;
    logic                       beat_ok;
    logic                       last_ok;
    logic [LINE_W-1:0]          line;

    assign beat_ok = i_r_valid & o_r_ready;
    assign last_ok = beat_ok & i_r.last;

    always_ff @(posedge i_aclk or negedge i_aresetn)
    begin
        if (!i_aresetn)
            state_q <= RD_IDLE;
        else
            state_q <= state_d;
    end

    // data side wins a tie
    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            RD_IDLE:
            begin
                if (i_d_rvalid)
                    state_d = RD_DADDR;
                else if (i_i_rvalid)
                    state_d = RD_IADDR;
            end
            RD_IADDR: if (i_ar_ready) state_d = RD_IDATA;
            RD_DADDR: if (i_ar_ready) state_d = RD_DDATA;
            RD_IDATA: if (last_ok) state_d = RD_IDLE;
            RD_DDATA: if (last_ok) state_d = RD_IDLE;
            default:  state_d = RD_IDLE;
        endcase
    end

    // only sampled while idle so the AR payload holds until accepted
    always_ff @(posedge i_aclk)
    begin
        if (state_q == RD_IDLE)
            addr_q <= i_d_rvalid ? i_d_raddr : i_i_raddr;
    end

    assign o_ar_valid = (state_q == RD_IADDR) || (state_q == RD_DADDR);
    assign o_r_ready  = (state_q == RD_IDATA) || (state_q == RD_DDATA);

    always_comb
    begin
        o_ar.id    = (state_q == RD_DADDR) ? ID_DATA : ID_INSTR;
        o_ar.addr  = addr_q;
        o_ar.len   = BURST_LEN;
        o_ar.size  = BURST_SIZE;
        o_ar.burst = BURST_INCR;
    end

    line_assembler u_asm (
        .i_aclk    (i_aclk),
        .i_aresetn (i_aresetn),
        .i_shift   (beat_ok & ~i_r.last),
        .i_beat    (i_r.data),
        .o_bits    (asm_bits)
    );

    assign line = {i_r.data, asm_bits};   // last beat on top

    // one-cycle ready pulse to whoever owns the burst
    assign o_i_rready = last_ok && (state_q == RD_IDATA);
    assign o_d_rready = last_ok && (state_q == RD_DDATA);
    assign o_i_rdata  = (state_q == RD_IDATA) ? line : '0;
    assign o_d_rdata  = (state_q == RD_DDATA) ? line : '0;

endmodule

`default_nettype wire

/* axi_bridge/line_serializer.sv */
`default_nettype none

module line_serializer
    import cache_axi_pkg::*;
(
    input  wire logic              i_aclk,
    input  wire logic              i_aresetn,
    input  wire logic              i_load,     // capture a new line
    input  wire logic [LINE_W-1:0] i_line,
    input  wire logic              i_advance,  // W beat accepted
    output logic [DATA_W-1:0]      o_beat
);

    logic [LINE_W-1:0] line_q;

    // load has priority, the engine never loads mid burst anyway
    always_ff @(posedge i_aclk or negedge i_aresetn)
    begin
        if (!i_aresetn)
        begin
            line_q <= '0;
        end
        else if (i_load)
        begin
            line_q <= i_line;
        end
        else if (i_advance)
        begin
            // next word drops into the low slot
            line_q <= {{DATA_W{1'b0}}, line_q[LINE_W-1:DATA_W]};
        end
    end

    assign o_beat = line_q[DATA_W-1:0];   // current W beat

endmodule

`default_nettype wire

/* axi_bridge/line_write_engine.sv */
`default_nettype none

module line_write_engine
    import cache_axi_pkg::*;
(
    input  wire logic                i_aclk,
    input  wire logic                i_aresetn,

    input  wire logic                i_d_wvalid,
    input  wire line_wr_req_t        i_wreq,
    output logic                     o_d_wready,

    output axi_aw_t                  o_aw,
    output logic                     o_aw_valid,
    input  wire logic                i_aw_ready,

    output logic [DATA_W-1:0]        o_w_data,
    output logic [DATA_W/8-1:0]      o_w_strb,
    output logic                     o_w_last,
    output logic                     o_w_valid,
    input  wire logic                i_w_ready,

    input  wire logic                i_b_valid,
    output logic                     o_b_ready
);

    wr_state_e                 state_q;
    wr_state_e                 state_d;
    logic [ADDR_W-1:0]         addr_q;
    logic [DATA_W/8-1:0]       strb_q;     // strobe after byte offset shift
    logic [3:0]                beat_q;     // wraps to 0 after the 16th beat
    logic                      take_req;
    logic                      w_ok;
    logic [LINE_W-1:0]         line_shifted;

    assign take_req = (state_q == WR_IDLE) && i_d_wvalid;
    assign w_ok     = o_w_valid & i_w_ready;

    always_ff @(posedge i_aclk or negedge i_aresetn)
    begin
        if (!i_aresetn)
            state_q <= WR_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            WR_IDLE: if (i_d_wvalid) state_d = WR_ADDR;
            WR_ADDR: if (i_aw_ready) state_d = WR_DATA;
            WR_DATA: if (w_ok && o_w_last) state_d = WR_RESP;
            WR_RESP: if (i_b_valid) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge i_aclk)
    begin
        if (take_req)
        begin
            addr_q <= i_wreq.addr;
            strb_q <= i_wreq.strobe << i_wreq.addr[1:0];
        end
    end

    // counts accepted beats only, a stalled w_ready holds it
    always_ff @(posedge i_aclk or negedge i_aresetn)
    begin
        if (!i_aresetn)
            beat_q <= '0;
        else if (w_ok)
            beat_q <= beat_q + 4'd1;
    end

    // byte offset moves the whole line up, top bytes fall off
    assign line_shifted = i_wreq.data << {i_wreq.addr[1:0], 3'b000};

    line_serializer u_ser (
        .i_aclk    (i_aclk),
        .i_aresetn (i_aresetn),
        .i_load    (take_req),
        .i_line    (line_shifted),
        .i_advance (w_ok),
        .o_beat    (o_w_data)
    );

    always_comb
    begin
        o_aw.addr  = addr_q;
        o_aw.len   = BURST_LEN;
        o_aw.size  = BURST_SIZE;
        o_aw.burst = BURST_INCR;
    end

    assign o_aw_valid = (state_q == WR_ADDR);
    assign o_w_valid  = (state_q == WR_DATA);
    assign o_w_strb   = strb_q;
    assign o_w_last   = o_w_valid && (beat_q == 4'(LINE_BEATS - 1));
    assign o_b_ready  = (state_q == WR_RESP);
    assign o_d_wready = o_b_ready & i_b_valid;   // done when B lands

endmodule

`default_nettype wire

/* design/cache_axi_top.sv */
`default_nettype none

module cache_axi_top
    import cache_axi_pkg::*;
(
    input  wire logic                i_aclk,
    input  wire logic                i_aresetn,

    // instruction cache reads
    input  wire logic                i_i_rvalid,
    input  wire logic [ADDR_W-1:0]   i_i_raddr,
    output logic                     o_i_rready,
    output logic [LINE_W-1:0]        o_i_rdata,

    // data cache reads
    input  wire logic                i_d_rvalid,
    input  wire logic [ADDR_W-1:0]   i_d_raddr,
    output logic                     o_d_rready,
    output logic [LINE_W-1:0]        o_d_rdata,

    // data cache writes
    input  wire logic                i_d_wvalid,
    input  wire line_wr_req_t        i_wreq,
    output logic                     o_d_wready,

    // AXI master
    output axi_ar_t                  o_ar,
    output logic                     o_ar_valid,
    input  wire logic                i_ar_ready,
    input  wire axi_r_t              i_r,
    input  wire logic                i_r_valid,
    output logic                     o_r_ready,
    output axi_aw_t                  o_aw,
    output logic                     o_aw_valid,
    input  wire logic                i_aw_ready,
    output logic [DATA_W-1:0]        o_w_data,
    output logic [DATA_W/8-1:0]      o_w_strb,
    output logic                     o_w_last,
    output logic                     o_w_valid,
    input  wire logic                i_w_ready,
    input  wire logic                i_b_valid,
    output logic                     o_b_ready
);

    // reads and writes run independently, one of each in flight
    line_read_engine u_rd (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_i_rvalid (i_i_rvalid),
        .i_i_raddr  (i_i_raddr),
        .i_d_rvalid (i_d_rvalid),
        .i_d_raddr  (i_d_raddr),
        .o_i_rready (o_i_rready),
        .o_i_rdata  (o_i_rdata),
        .o_d_rready (o_d_rready),
        .o_d_rdata  (o_d_rdata),
        .o_ar       (o_ar),
        .o_ar_valid (o_ar_valid),
        .i_ar_ready (i_ar_ready),
        .i_r        (i_r),
        .i_r_valid  (i_r_valid),
        .o_r_ready  (o_r_ready)
    );

    line_write_engine u_wr (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_d_wvalid (i_d_wvalid),
        .i_wreq     (i_wreq),
        .o_d_wready (o_d_wready),
        .o_aw       (o_aw),
        .o_aw_valid (o_aw_valid),
        .i_aw_ready (i_aw_ready),
        .o_w_data   (o_w_data),
        .o_w_strb   (o_w_strb),
        .o_w_last   (o_w_last),
        .o_w_valid  (o_w_valid),
        .i_w_ready  (i_w_ready),
        .i_b_valid  (i_b_valid),
        .o_b_ready  (o_b_ready)
    );

endmodule

`default_nettype wire

/* test/cache_axi_sva.sv */
`default_nettype none

module cache_axi_sva
    import cache_axi_pkg::*;
(
    input wire logic                i_aclk,
    input wire logic                i_aresetn,
    input wire axi_ar_t             o_ar,
    input wire logic                o_ar_valid,
    input wire logic                i_ar_ready,
    input wire axi_aw_t             o_aw,
    input wire logic                o_aw_valid,
    input wire logic                i_aw_ready,
    input wire logic [DATA_W-1:0]   o_w_data,
    input wire logic [DATA_W/8-1:0] o_w_strb,
    input wire logic                o_w_last,
    input wire logic                o_w_valid,
    input wire logic                i_w_ready,
    input wire logic                o_r_ready,
    input wire logic                o_b_ready,
    input wire logic                o_i_rready,
    input wire logic                o_d_rready,
    input wire logic                o_d_wready
);

    // a pending valid holds until its handshake
    ar_hold: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar))
        else $error("ar_valid dropped or AR payload changed before handshake");

    aw_hold: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw))
        else $error("aw_valid dropped or AW payload changed before handshake");

    w_hold: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_w_valid && !i_w_ready |=> o_w_valid && $stable({o_w_data, o_w_strb, o_w_last}))
        else $error("w_valid dropped or W payload changed before handshake");

    // everything quiet while reset is held
    reset_quiet: assert property (@(posedge i_aclk)
        !i_aresetn |-> !(o_ar_valid || o_aw_valid || o_w_valid || o_r_ready
                         || o_b_ready || o_i_rready || o_d_rready || o_d_wready))
        else $error("control output high during reset");

endmodule

bind cache_axi_top cache_axi_sva u_sva (.*);

`default_nettype wire

/* test/cache_axi_checker.sv */
`default_nettype none

module cache_axi_checker
    import cache_axi_pkg::*;
(
    input wire logic                i_aclk,
    input wire logic                i_aresetn,
    input wire logic                i_i_rvalid,
    input wire logic [ADDR_W-1:0]   i_i_raddr,
    input wire logic                i_i_rready,
    input wire logic [LINE_W-1:0]   i_i_rdata,
    input wire logic                i_d_rvalid,
    input wire logic [ADDR_W-1:0]   i_d_raddr,
    input wire logic                i_d_rready,
    input wire logic [LINE_W-1:0]   i_d_rdata,
    input wire logic                i_d_wvalid,
    input wire line_wr_req_t        i_wreq,
    input wire logic                i_d_wready,
    input wire axi_ar_t             i_ar,
    input wire logic                i_ar_valid,
    input wire logic                i_ar_ready,
    input wire logic                i_r_ready,
    input wire axi_aw_t             i_aw,
    input wire logic                i_aw_valid,
    input wire logic                i_aw_ready,
    input wire logic [DATA_W-1:0]   i_w_data,
    input wire logic [DATA_W/8-1:0] i_w_strb,
    input wire logic                i_w_last,
    input wire logic                i_w_valid,
    input wire logic                i_w_ready,
    input wire logic                i_b_ready,
    output int                      o_errors
);

    logic [7:0] mem [0:4095];   // byte model of slave memory
    logic [3:0] wr_strb;        // shifted strobe of the write being retired
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         failed_tests = 0;
    int         test_start = 0;
    int         wbeat = 0;

    assign o_errors = errors;

    // same fill as the slave memory, depends on all 12 address bits
    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ ({4'b0000, a[11:8]} * 8'd37);
    endfunction

    function automatic logic [LINE_W-1:0] model_line(input logic [ADDR_W-1:0] a);
        logic [LINE_W-1:0] l;
        for (int n = 0; n < 64; n++)
            l[n*8 +: 8] = mem[12'(int'(a[11:0]) + n)];
        return l;
    endfunction

    // byte n of the line after the offset moves it up
    function automatic logic [7:0] moved_byte(input line_wr_req_t rq, input int n);
        int off;
        off = int'(rq.addr[1:0]);
        if (n < off || n - off > 63)
            return 8'h00;
        return rq.data[(n - off)*8 +: 8];
    endfunction

    function automatic logic [3:0] moved_strb(input line_wr_req_t rq);
        logic [3:0] s;
        s = 4'b0000;
        for (int b = 0; b < 4; b++)
            if (b >= int'(rq.addr[1:0]))
                s[b] = rq.strobe[b - int'(rq.addr[1:0])];
        return s;
    endfunction

    task automatic value_err(input string sig, input logic [LINE_W-1:0] exp,
                             input logic [LINE_W-1:0] got);
        $display("ERR t=%0t %s exp=%0h got=%0h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic note_err(input string msg);
        $display("error at t=%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != test_start)
            failed_tests++;
        $display("test %0d %-32s %s", tests, name, (errors == test_start) ? "ok" : "failed");
        test_start = errors;
    endtask

    task automatic summary();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
    endtask

    initial
    begin
        for (int a = 0; a < 4096; a++)
            mem[a] = fill_byte(12'(a));
    end

    always @(posedge i_aclk)
    begin
        if (i_aresetn)
        begin
            if ((i_ar_valid || i_r_ready) && !(i_i_rvalid || i_d_rvalid))
                note_err("ar_valid or r_ready raised with no read request");
            if ((i_aw_valid || i_w_valid || i_b_ready) && !i_d_wvalid)
                note_err("aw_valid, w_valid or b_ready raised with no write request");
            if (i_i_rready && !i_i_rvalid)
                note_err("extra i_rready pulse");
            if (i_d_rready && !i_d_rvalid)
                note_err("extra d_rready pulse");
            if (i_d_wready && !i_d_wvalid)
                note_err("extra d_wready pulse");
            // data wins when both are waiting
            if (i_ar_valid && i_ar_ready)
            begin
                checks++;
                if (i_ar.id !== (i_d_rvalid ? ID_DATA : ID_INSTR))
                    value_err("ar_id", LINE_W'(i_d_rvalid ? ID_DATA : ID_INSTR), LINE_W'(i_ar.id));
                if (i_ar.addr !== (i_d_rvalid ? i_d_raddr : i_i_raddr))
                    value_err("ar_addr", LINE_W'(i_d_rvalid ? i_d_raddr : i_i_raddr),
                              LINE_W'(i_ar.addr));
                if ({i_ar.len, i_ar.size, i_ar.burst} !== {BURST_LEN, BURST_SIZE, BURST_INCR})
                    value_err("ar_len_size_burst", LINE_W'({BURST_LEN, BURST_SIZE, BURST_INCR}),
                              LINE_W'({i_ar.len, i_ar.size, i_ar.burst}));
            end
            if (i_aw_valid && i_aw_ready)
            begin
                checks++;
                if (i_aw.addr !== i_wreq.addr)
                    value_err("aw_addr", LINE_W'(i_wreq.addr), LINE_W'(i_aw.addr));
                if ({i_aw.len, i_aw.size, i_aw.burst} !== {BURST_LEN, BURST_SIZE, BURST_INCR})
                    value_err("aw_len_size_burst", LINE_W'({BURST_LEN, BURST_SIZE, BURST_INCR}),
                              LINE_W'({i_aw.len, i_aw.size, i_aw.burst}));
            end
            if (i_i_rready && i_i_rvalid)
            begin
                checks++;
                if (i_i_rdata !== model_line(i_i_raddr))
                    value_err("i_rdata", model_line(i_i_raddr), i_i_rdata);
            end
            if (i_d_rready && i_d_rvalid)
            begin
                checks++;
                if (i_d_rdata !== model_line(i_d_raddr))
                    value_err("d_rdata", model_line(i_d_raddr), i_d_rdata);
            end
            if (i_w_valid && i_w_ready)
            begin
                checks++;
                for (int b = 0; b < 4; b++)
                    if (i_w_data[b*8 +: 8] !== moved_byte(i_wreq, wbeat*4 + b))
                        value_err($sformatf("w_data beat %0d byte %0d", wbeat, b),
                                  LINE_W'(moved_byte(i_wreq, wbeat*4 + b)),
                                  LINE_W'(i_w_data[b*8 +: 8]));
                if (i_w_strb !== moved_strb(i_wreq))
                    value_err("w_strb", LINE_W'(moved_strb(i_wreq)), LINE_W'(i_w_strb));
                if (i_w_last !== (wbeat == LINE_BEATS - 1))
                    value_err("w_last", LINE_W'(wbeat == LINE_BEATS - 1), LINE_W'(i_w_last));
                wbeat++;
            end
            if (i_d_wready && i_d_wvalid)
            begin
                checks++;
                if (wbeat != LINE_BEATS)
                    note_err($sformatf("write finished after %0d W beats instead of 16", wbeat));
                // every beat writes the strobed bytes of its word
                wr_strb = moved_strb(i_wreq);
                for (int n = 0; n < 64; n++)
                    if (wr_strb[n % 4])
                        mem[12'(int'({i_wreq.addr[11:2], 2'b00}) + n)] = moved_byte(i_wreq, n);
                wbeat = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_cache_axi.sv */
`default_nettype none

module tb_cache_axi
    import cache_axi_pkg::*;
();

    localparam int RESET_CYC   = 16;
    localparam int NUM_TRANS   = 40;
    localparam int CYC_PER     = 80;
    localparam int TIMEOUT_CYC = RESET_CYC + NUM_TRANS * CYC_PER + 84;   // 3300

    logic aclk;
    logic aresetn;
    logic ic_rvalid, dc_rvalid, dc_wvalid;
    logic [ADDR_W-1:0] ic_raddr, dc_raddr;
    line_wr_req_t wreq;
    logic ic_rready, dc_rready, dc_wready;
    logic [LINE_W-1:0] ic_rdata, dc_rdata;
    axi_ar_t ar;
    axi_aw_t aw;
    axi_r_t  r;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic [DATA_W-1:0] w_data;
    logic [3:0] w_strb;
    logic w_last, w_valid, w_ready, b_valid, b_ready;
    int errors;
    int seed = 32'h2a46;
    int cycles = 0;

    logic [31:0] smem [0:1023];   // slave memory, one word per entry
    logic        rd_busy, b_pend;
    logic [9:0]  rd_word, wr_word;
    logic [3:0]  rd_id;
    int          rd_cnt, w_cnt;

    cache_axi_top u_dut (
        .i_aclk(aclk), .i_aresetn(aresetn),
        .i_i_rvalid(ic_rvalid), .i_i_raddr(ic_raddr), .o_i_rready(ic_rready), .o_i_rdata(ic_rdata),
        .i_d_rvalid(dc_rvalid), .i_d_raddr(dc_raddr), .o_d_rready(dc_rready), .o_d_rdata(dc_rdata),
        .i_d_wvalid(dc_wvalid), .i_wreq(wreq), .o_d_wready(dc_wready),
        .o_ar(ar), .o_ar_valid(ar_valid), .i_ar_ready(ar_ready),
        .i_r(r), .i_r_valid(r_valid), .o_r_ready(r_ready),
        .o_aw(aw), .o_aw_valid(aw_valid), .i_aw_ready(aw_ready),
        .o_w_data(w_data), .o_w_strb(w_strb), .o_w_last(w_last), .o_w_valid(w_valid),
        .i_w_ready(w_ready), .i_b_valid(b_valid), .o_b_ready(b_ready)
    );

    cache_axi_checker u_chk (
        .i_aclk(aclk), .i_aresetn(aresetn),
        .i_i_rvalid(ic_rvalid), .i_i_raddr(ic_raddr), .i_i_rready(ic_rready), .i_i_rdata(ic_rdata),
        .i_d_rvalid(dc_rvalid), .i_d_raddr(dc_raddr), .i_d_rready(dc_rready), .i_d_rdata(dc_rdata),
        .i_d_wvalid(dc_wvalid), .i_wreq(wreq), .i_d_wready(dc_wready),
        .i_ar(ar), .i_ar_valid(ar_valid), .i_ar_ready(ar_ready), .i_r_ready(r_ready),
        .i_aw(aw), .i_aw_valid(aw_valid), .i_aw_ready(aw_ready),
        .i_w_data(w_data), .i_w_strb(w_strb), .i_w_last(w_last), .i_w_valid(w_valid),
        .i_w_ready(w_ready), .i_b_ready(b_ready), .o_errors(errors)
    );

    always #50 aclk = ~aclk;

    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ ({4'b0000, a[11:8]} * 8'd37);
    endfunction

    // ready or valid about three times in four
    function automatic logic go_bit();
        logic [31:0] rv;
        rv = $random(seed);
        return rv[1:0] != 2'b00;
    endfunction

    function automatic logic [ADDR_W-1:0] pick_line_addr();
        logic [31:0] rv;
        rv = $random(seed);
        return {20'd0, rv[5:0], 6'd0};
    endfunction

    // simple AXI slave, handshakes sampled on the edge, outputs driven just after
    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            rd_busy = 1'b0;
            b_pend  = 1'b0;
            rd_word = '0;
            rd_id   = '0;
            rd_cnt  = 0;
            w_cnt   = 0;
        end
        else
        begin
            if (ar_valid && ar_ready)
            begin
                rd_busy = 1'b1;
                rd_word = ar.addr[11:2];
                rd_id   = ar.id;
                rd_cnt  = 0;
            end
            if (r_valid && r_ready)
            begin
                rd_cnt++;
                if (rd_cnt == LINE_BEATS)
                    rd_busy = 1'b0;
            end
            if (aw_valid && aw_ready)
            begin
                wr_word = aw.addr[11:2];
                w_cnt   = 0;
            end
            if (w_valid && w_ready)
            begin
                for (int b = 0; b < 4; b++)
                    if (w_strb[b])
                        smem[wr_word + 10'(w_cnt)][b*8 +: 8] = w_data[b*8 +: 8];
                w_cnt++;
                if (w_last)
                    b_pend = 1'b1;
            end
            if (b_valid && b_ready)
                b_pend = 1'b0;
        end
        #1;
        ar_ready = aresetn && go_bit();
        aw_ready = aresetn && go_bit();
        w_ready  = aresetn && go_bit();
        r_valid  = rd_busy && go_bit();
        b_valid  = b_pend && go_bit();
        r.id     = rd_id;
        r.data   = smem[rd_word + 10'(rd_cnt)];
        r.last   = (rd_cnt == LINE_BEATS - 1);
    end

    task automatic read_line(input logic use_d, input logic [ADDR_W-1:0] addr);
        if (use_d)
        begin
            dc_rvalid = 1'b1;
            dc_raddr  = addr;
        end
        else
        begin
            ic_rvalid = 1'b1;
            ic_raddr  = addr;
        end
        @(posedge aclk);
        while (!(use_d ? dc_rready : ic_rready))
            @(posedge aclk);
        #1;
        if (use_d)
            dc_rvalid = 1'b0;
        else
            ic_rvalid = 1'b0;
    endtask

    task automatic write_line(input logic [ADDR_W-1:0] addr);
        logic [31:0] rv;
        for (int k = 0; k < LINE_BEATS; k++)
            wreq.data[k*32 +: 32] = $random(seed);
        rv = $random(seed);
        wreq.strobe = rv[3:0];
        wreq.addr   = addr;
        dc_wvalid   = 1'b1;
        @(posedge aclk);
        while (!dc_wready)
            @(posedge aclk);
        #1;
        dc_wvalid = 1'b0;
    endtask

    initial
    begin
        forever
        begin
            @(posedge aclk);
            cycles++;
            if (cycles >= TIMEOUT_CYC)
            begin
                $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    initial
    begin
        logic [ADDR_W-1:0] a0;
        logic [31:0] rv;
        for (int w = 0; w < 1024; w++)
            for (int b = 0; b < 4; b++)
                smem[w][b*8 +: 8] = fill_byte(12'(w*4 + b));
        aclk = 1'b0;
        aresetn = 1'b0;
        {ic_rvalid, dc_rvalid, dc_wvalid} = 3'b000;
        ic_raddr = '0;
        dc_raddr = '0;
        wreq = '0;
        {ar_ready, r_valid, aw_ready, w_ready, b_valid} = 5'b00000;
        r = '0;
        repeat (RESET_CYC) @(posedge aclk);
        #1 aresetn = 1'b1;

        repeat (10) @(posedge aclk);
        #1;
        u_chk.close_test("idle after reset");

        for (int i = 0; i < 8; i++)
            read_line(1'b0, pick_line_addr());
        u_chk.close_test("instruction line reads");

        for (int i = 0; i < 4; i++)
        begin
            a0 = pick_line_addr();
            fork
                read_line(1'b1, a0);
                read_line(1'b0, pick_line_addr());
            join
        end
        u_chk.close_test("data over instruction");

        for (int i = 0; i < 8; i++)
        begin
            rv = $random(seed);
            a0 = pick_line_addr();
            write_line(a0 | {30'd0, rv[1:0]});
            read_line(1'b1, a0);
        end
        u_chk.close_test("offset writes with readback");

        for (int i = 0; i < 4; i++)
        begin
            a0 = pick_line_addr();
            fork
                write_line(a0 + 32'd1);
                read_line(1'b0, a0 ^ 32'h0000_0040);
            join
            read_line(1'b0, a0);
        end
        u_chk.close_test("reads and writes overlapped");

        repeat (4) @(posedge aclk);
        u_chk.summary();
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/cache_axi_pkg.sv
axi_bridge/line_assembler.sv
axi_bridge/line_read_engine.sv
axi_bridge/line_serializer.sv
axi_bridge/line_write_engine.sv
design/cache_axi_top.sv
test/cache_axi_sva.sv
test/cache_axi_checker.sv
test/tb_cache_axi.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_cache_axi -o tb_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation finished: PASS" sim.log && echo "run passed" \
    || { echo "run failed, see sim.log"; exit 1; }
